// File: rvPipe.f
+incdir+.
rvPipePkg.sv
fetchStage.sv
decodeStage.sv
regFile.sv
executeStage.sv
memoryStage.sv
rvPipeTop.sv
rvPipeTb.sv

// File: rvPipeTb.sv
`timescale 1ns/1ps
`include "rvPipe_params.svh"

module rvPipeTb;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int TIMEOUT    = 2000; // cycles per wait
	localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        stall = 1'b0;
	logic [31:0] instrAddress;
	logic [31:0] instrData;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic        memWe;
	logic [31:0] memRdata;

	logic [31:0] imem [0:IMEM_WORDS-1];
	logic [31:0] dmem [0:DMEM_WORDS-1];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	int          progLen;
	int          storeIdx;
	int          errors;
	int          seed;
	logic        randomStall = 1'b0;
	logic [31:0] rnd;
	logic [31:0] pcModel;
	logic        resetSeen = 1'b0;

	rvPipeTop UUT (
		.clk, .reset, .stall,
		.instrAddress, .instrData,
		.memAddr, .memWdata, .memWe, .memRdata
	);

	always #20 clk = ~clk; // 40 ns period

	// ------------------------------
	// memory models
	// ------------------------------
	assign instrData = (instrAddress < IMEM_WORDS * 4) ? imem[instrAddress[7:2]] : NOP;
	assign memRdata  = dmem[memAddr[7:2]];

	always @(posedge clk) begin
		if (memWe === 1'b1) begin
			dmem[memAddr[7:2]] <= memWdata;
		end
	end

	// every byte keeps its top bit set
	function automatic logic [31:0] dataPattern(input int idx);
		return 32'hF0E0_8080 ^ (idx * 32'h0101_0101);
	endfunction

	function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic logic [31:0] immOp(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, `OPC_OPIMM};
	endfunction

	function automatic logic [31:0] loadOp(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, `OPC_LOAD};
	endfunction

	function automatic logic [31:0] storeOp(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE}; // sw
	endfunction

	function automatic logic [31:0] luiOp(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, `OPC_LUI};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	task automatic buildProgram();
		int k;
		for (k = 0; k < IMEM_WORDS; k++) imem[k] = NOP;
		progLen = 0;
		emit(immOp(3'b000, 1, 0, -7));
		emit(immOp(3'b000, 2, 0, 5));
		emit(regOp(7'h00, 3'b000, 3, 1, 2)); // add, both operands forwarded
		emit(regOp(7'h20, 3'b000, 4, 3, 2)); // sub
		emit(regOp(7'h00, 3'b111, 5, 4, 1)); // and
		emit(regOp(7'h00, 3'b110, 6, 5, 3)); // or, x3 via write-through
		emit(regOp(7'h00, 3'b100, 7, 6, 4)); // xor
		emit(regOp(7'h00, 3'b010, 8, 1, 2)); // slt -7 < 5
		emit(regOp(7'h00, 3'b010, 9, 2, 3)); // slt 5 < -2
		emit(immOp(3'b000, 10, 0, 128));     // store base
		for (k = 3; k <= 9; k++) emit(storeOp(k, 10, (k - 3) * 4));
		emit(immOp(3'b000, 11, 1, -100));
		emit(immOp(3'b111, 12, 11, -16));
		emit(immOp(3'b110, 13, 12, -1366));
		emit(immOp(3'b100, 14, 13, -1));
		emit(immOp(3'b010, 15, 1, -3));
		emit(immOp(3'b010, 16, 2, -3));
		emit(luiOp(17, 20'hABCDE));
		emit(immOp(3'b000, 17, 17, -1));
		for (k = 11; k <= 17; k++) emit(storeOp(k, 10, (k - 4) * 4));
		// loads, one instruction between load and consumer
		emit(loadOp(3'b010, 18, 0, 4));  // lw
		emit(loadOp(3'b001, 19, 0, 8));  // lh
		emit(storeOp(18, 10, 56));
		emit(loadOp(3'b000, 20, 0, 12)); // lb
		emit(storeOp(19, 10, 60));
		emit(loadOp(3'b101, 21, 0, 16)); // lhu
		emit(storeOp(20, 10, 64));
		emit(loadOp(3'b100, 22, 0, 20)); // lbu
		emit(storeOp(21, 10, 68));
		emit(immOp(3'b000, 23, 0, 1));
		emit(storeOp(22, 10, 72));
		emit(immOp(3'b000, 0, 0, 55));   // must be discarded
		emit(storeOp(0, 10, 76));
		emit(loadOp(3'b010, 24, 10, 0)); // reads back an earlier store
		emit(NOP);
		emit(storeOp(24, 10, 80));
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [31:0] aluResultFor(input logic [2:0] f3, input logic isSub,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'b000:  return isSub ? x - y : x + y;
			3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'b100:  return x ^ y;
			3'b110:  return x | y;
			3'b111:  return x & y;
			default: return '0;
		endcase
	endfunction

	function automatic void buildExpected();
		logic [31:0] refRegs [0:31];
		logic [31:0] refMem [0:DMEM_WORDS-1];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] immI;
		logic [31:0] immS;
		logic        writes;
		int          k;
		expAddr.delete();
		expData.delete();
		for (k = 0; k < 32; k++) refRegs[k] = '0;
		for (k = 0; k < DMEM_WORDS; k++) refMem[k] = dataPattern(k);
		for (k = 0; k < progLen; k++) begin
			w      = imem[k];
			a      = refRegs[w[19:15]];
			b      = refRegs[w[24:20]];
			immI   = {{20{w[31]}}, w[31:20]};
			immS   = {{20{w[31]}}, w[31:25], w[11:7]};
			writes = 1'b1;
			res    = '0;
			case (w[6:0])
				`OPC_OP:    res = aluResultFor(w[14:12], w[30], a, b);
				`OPC_OPIMM: res = aluResultFor(w[14:12], 1'b0, a, immI);
				`OPC_LUI:   res = {w[31:12], 12'b0};
				`OPC_LOAD: begin
					addr = a + immI;
					word = refMem[addr[7:2]];
					case (w[14:12])
						3'b000:  res = {{24{word[7]}}, word[7:0]};
						3'b001:  res = {{16{word[15]}}, word[15:0]};
						3'b100:  res = {24'b0, word[7:0]};
						3'b101:  res = {16'b0, word[15:0]};
						default: res = word;
					endcase
				end
				`OPC_STORE: begin
					addr = a + immS;
					refMem[addr[7:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && w[11:7] != 5'd0) refRegs[w[11:7]] = res;
		end
	endfunction

	// ------------------------------
	// stall and checker
	// ------------------------------
	always @(posedge clk) begin
		rnd = $random(seed);
		stall <= randomStall & rnd[0];
	end

	always @(posedge clk) begin
		if (resetSeen) begin
			assert (instrAddress === pcModel) else begin
				errors++;
				$display("FAIL at %0t instrAddress: expected %h, got %h",
					$time, pcModel, instrAddress);
			end
		end
		if (reset) begin
			if (resetSeen) begin
				assert (memWe === 1'b0) else begin
					errors++;
					$display("FAIL at %0t memWe: expected 0, got %b", $time, memWe);
				end
			end
		end else if (memWe === 1'b1) begin
			assert (storeIdx < expAddr.size()) else begin
				errors++;
				$display("Unexpected extra store at %0t to address %h", $time, memAddr);
			end
			if (storeIdx < expAddr.size()) begin
				assert (memAddr == expAddr[storeIdx]) else begin
					errors++;
					$display("FAIL at %0t memAddr: expected %h, got %h",
						$time, expAddr[storeIdx], memAddr);
				end
				assert (memWdata == expData[storeIdx]) else begin
					errors++;
					$display("FAIL at %0t memWdata: expected %h, got %h",
						$time, expData[storeIdx], memWdata);
				end
			end
			storeIdx++;
		end
		// PC after this edge, cleared by reset and stepped by 4 when not stalled
		if (reset) begin
			pcModel   = '0;
			resetSeen = 1'b1;
		end else if (!stall) begin
			pcModel = pcModel + 32'd4;
		end
	end

	task automatic runProgram(input logic withStall);
		int k;
		int cycles;
		@(posedge clk);
		reset       <= 1'b1;
		randomStall <= 1'b0;
		for (k = 0; k < DMEM_WORDS; k++) dmem[k] = dataPattern(k); // fresh data each run
		storeIdx = 0;
		for (k = 0; k < 8; k++) @(posedge clk);
		reset       <= 1'b0;
		randomStall <= withStall;
		cycles = 0;
		while (storeIdx < expAddr.size() && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		assert (storeIdx >= expAddr.size()) else begin
			errors++;
			$display("Timed out: only %0d of %0d stores reached memory", storeIdx,
				expAddr.size());
		end
		cycles = 0;
		while (cycles < 20) begin // drain, catches duplicates
			@(posedge clk);
			cycles++;
		end
	endtask

	initial begin
		seed   = 52713;
		errors = 0;
		buildProgram();
		buildExpected();
		runProgram(1'b0);
		runProgram(1'b1); // same stores expected under random stall
		$display("Errors: %0d, stores per run: %0d", errors, expAddr.size());
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: rvPipeTop.sv
`timescale 1ns/1ps
`include "rvPipe_params.svh"

module rvPipeTop import rvPipePkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	output logic [`XLEN-1:0] instrAddress,
	input  logic [`XLEN-1:0] instrData,
	output logic [`XLEN-1:0] memAddr,
	output logic [`XLEN-1:0] memWdata,
	output logic             memWe,
	input  logic [`XLEN-1:0] memRdata
);

	logic                   ifValid;
	instrWord_t             ifInstr;
	logic [`REG_ADDR_W-1:0] rs1Addr;
	logic [`REG_ADDR_W-1:0] rs2Addr;
	logic [`XLEN-1:0]       rs1Data;
	logic [`XLEN-1:0]       rs2Data;
	decodedOp_t             idOp;
	memOp_t                 exOp;
	wbEntry_t               wb; // regfile write and forwarding

	// ------------------------------
	// pipeline
	// ------------------------------
	fetchStage fetch (
		.clk, .reset, .stall,
		.instrData    (instrData),
		.instrAddress (instrAddress),
		.ifValid, .ifInstr
	);

	decodeStage decode (
		.clk, .reset, .stall,
		.ifValid, .ifInstr,
		.rs1Addr, .rs2Addr,
		.rs1Data, .rs2Data,
		.idOp
	);

	regFile regs (
		.clk,
		.rs1Addr, .rs2Addr,
		.rs1Data, .rs2Data,
		.wb
	);

	executeStage execute (
		.clk, .reset, .stall,
		.idOp,
		.memFwd (exOp),
		.wbFwd  (wb),
		.exOp
	);

	memoryStage memory (
		.clk, .reset, .stall,
		.exOp,
		.memAddr, .memWdata, .memWe, .memRdata,
		.wb
	);

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps
`include "rvPipe_params.svh"

module memoryStage import rvPipePkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  memOp_t           exOp,
	output logic [`XLEN-1:0] memAddr,
	output logic [`XLEN-1:0] memWdata,
	output logic             memWe,
	input  logic [`XLEN-1:0] memRdata,
	output wbEntry_t         wb
);

	logic [`XLEN-1:0] loadData;

	// low byte or halfword of the returned word, sign or zero filled
	function automatic logic [`XLEN-1:0] extendLoad(
		input logic [`XLEN-1:0] word,
		input loadKind_t        kind
	);
		case (kind)
			LK_HALFU: return {16'b0, word[15:0]};
			LK_BYTEU: return {24'b0, word[7:0]};
			LK_HALF:  return {{16{word[15]}}, word[15:0]};
			LK_BYTE:  return {{24{word[7]}}, word[7:0]};
			default:  return word;
		endcase
	endfunction

	// ------------------------------
	// data memory port
	// ------------------------------
	assign memAddr  = exOp.aluResult;
	assign memWdata = exOp.storeData;
	assign memWe    = exOp.valid && exOp.isStore && !stall; // one pulse per store

	assign loadData = extendLoad(memRdata, exOp.loadKind);

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (reset) begin
			wb <= '0;
		end else if (!stall) begin
			wb.regWrite <= exOp.regWrite;
			wb.rd       <= exOp.rd;
			wb.data     <= exOp.isLoad ? loadData : exOp.aluResult;
		end
	end

endmodule

// File: executeStage.sv
`timescale 1ns/1ps
`include "rvPipe_params.svh"

module executeStage import rvPipePkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       stall,
	input  decodedOp_t idOp,
	input  memOp_t     memFwd,
	input  wbEntry_t   wbFwd,
	output memOp_t     exOp
);

	logic [`XLEN-1:0] srcA;
	logic [`XLEN-1:0] srcB;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluResult;
	memOp_t           exNext;

	// ------------------------------
	// forwarding
	// ------------------------------
	// memory stage wins over writeback, a load in memory has no data yet
	function automatic logic [`XLEN-1:0] forward(
		input logic [`REG_ADDR_W-1:0] rs,
		input logic [`XLEN-1:0]       regData,
		input memOp_t                 memSrc,
		input wbEntry_t               wbSrc
	);
		if (rs == '0) begin
			return regData;
		end else if (memSrc.valid && memSrc.regWrite && !memSrc.isLoad && memSrc.rd == rs) begin
			return memSrc.aluResult;
		end else if (wbSrc.regWrite && wbSrc.rd == rs) begin
			return wbSrc.data;
		end
		return regData;
	endfunction

	always_comb begin
		srcA = forward(idOp.rs1, idOp.rs1Data, memFwd, wbFwd);
		srcB = forward(idOp.rs2, idOp.rs2Data, memFwd, wbFwd);
		opB  = idOp.useImm ? idOp.imm : srcB;
	end

	// ------------------------------
	// ALU
	// ------------------------------
	always_comb begin
		case (idOp.aluOp)
			ALU_ADD:   aluResult = srcA + opB;
			ALU_SUB:   aluResult = srcA - opB;
			ALU_AND:   aluResult = srcA & opB;
			ALU_OR:    aluResult = srcA | opB;
			ALU_XOR:   aluResult = srcA ^ opB;
			ALU_SLT:   aluResult = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(opB)};
			ALU_PASSB: aluResult = opB; // lui
			default:   aluResult = '0;
		endcase
	end

	always_comb begin
		exNext.valid     = idOp.valid;
		exNext.regWrite  = idOp.regWrite;
		exNext.isLoad    = idOp.isLoad;
		exNext.isStore   = idOp.isStore;
		exNext.loadKind  = idOp.loadKind;
		exNext.rd        = idOp.rd;
		exNext.aluResult = aluResult;
		exNext.storeData = srcB; // rs2 after forwarding
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset) begin
			exOp <= '0;
		end else if (!stall) begin
			exOp <= exNext;
		end
	end

endmodule

// File: regFile.sv
`timescale 1ns/1ps
`include "rvPipe_params.svh"

module regFile import rvPipePkg::*; (
	input  logic                   clk,
	input  logic [`REG_ADDR_W-1:0] rs1Addr,
	input  logic [`REG_ADDR_W-1:0] rs2Addr,
	output logic [`XLEN-1:0]       rs1Data,
	output logic [`XLEN-1:0]       rs2Data,
	input  wbEntry_t               wb
);

	logic [`XLEN-1:0] regs [1:`REG_COUNT-1]; // x0 has no storage
	logic             writeEn;

	assign writeEn = wb.regWrite && (wb.rd != '0);

	always_ff @(posedge clk) begin
		if (writeEn) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// x0 reads zero, a write in this cycle passes straight through
	function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0) begin
			return '0;
		end else if (writeEn && (wb.rd == addr)) begin
			return wb.data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1Data = readPort(rs1Addr);
		rs2Data = readPort(rs2Addr);
	end

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps
`include "rvPipe_params.svh"

module decodeStage import rvPipePkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	input  logic                   ifValid,
	input  instrWord_t             ifInstr,
	output logic [`REG_ADDR_W-1:0] rs1Addr,
	output logic [`REG_ADDR_W-1:0] rs2Addr,
	input  logic [`XLEN-1:0]       rs1Data,
	input  logic [`XLEN-1:0]       rs2Data,
	output decodedOp_t             idOp
);

	decodedOp_t       decoded;
	logic             known;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immU;

	// funct3 codes shared by OP and OP-IMM
	function automatic logic aluKnown(input logic [2:0] f3);
		return f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
	endfunction

	function automatic aluOp_t aluFor(input logic [2:0] f3, input logic isSub);
		case (f3)
			3'b000:  return isSub ? ALU_SUB : ALU_ADD;
			3'b010:  return ALU_SLT;
			3'b100:  return ALU_XOR;
			3'b110:  return ALU_OR;
			3'b111:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	assign rs1Addr = ifInstr.r.rs1;
	assign rs2Addr = ifInstr.r.rs2;

	assign immI = {{20{ifInstr.i.imm[11]}}, ifInstr.i.imm};
	assign immS = {{20{ifInstr.s.immHi[6]}}, ifInstr.s.immHi, ifInstr.s.immLo};
	assign immU = {ifInstr.u.imm, 12'b0};

	// ------------------------------
	// opcode decode
	// ------------------------------
	always_comb begin
		decoded         = '0;
		decoded.aluOp   = ALU_ADD;
		decoded.loadKind = LK_WORD;
		decoded.rd      = ifInstr.r.rd;
		decoded.rs1     = ifInstr.r.rs1;
		decoded.rs2     = ifInstr.r.rs2;
		decoded.rs1Data = rs1Data;
		decoded.rs2Data = rs2Data;
		known           = 1'b1;
		case (ifInstr.r.opcode)
			`OPC_OP: begin
				decoded.regWrite = 1'b1;
				decoded.aluOp    = aluFor(ifInstr.r.funct3, ifInstr.r.funct7[5]);
				known            = aluKnown(ifInstr.r.funct3);
			end
			`OPC_OPIMM: begin
				decoded.regWrite = 1'b1;
				decoded.useImm   = 1'b1;
				decoded.imm      = immI;
				decoded.aluOp    = aluFor(ifInstr.i.funct3, 1'b0); // no SUBI
				known            = aluKnown(ifInstr.i.funct3);
			end
			`OPC_LUI: begin
				decoded.regWrite = 1'b1;
				decoded.useImm   = 1'b1;
				decoded.imm      = immU;
				decoded.aluOp    = ALU_PASSB;
			end
			`OPC_LOAD: begin
				decoded.regWrite = 1'b1;
				decoded.isLoad   = 1'b1;
				decoded.useImm   = 1'b1;
				decoded.imm      = immI; // address = rs1 + imm
				case (ifInstr.i.funct3)
					3'b010:  decoded.loadKind = LK_WORD;
					3'b001:  decoded.loadKind = LK_HALF;
					3'b000:  decoded.loadKind = LK_BYTE;
					3'b101:  decoded.loadKind = LK_HALFU;
					3'b100:  decoded.loadKind = LK_BYTEU;
					default: known = 1'b0;
				endcase
			end
			`OPC_STORE: begin
				decoded.isStore = 1'b1;
				decoded.useImm  = 1'b1;
				decoded.imm     = immS;
				known           = (ifInstr.s.funct3 == 3'b010); // SW only
			end
			default: known = 1'b0;
		endcase

		// anything unsupported leaves as a bubble
		if (ifValid && known) begin
			decoded.valid = 1'b1;
		end else begin
			decoded.valid    = 1'b0;
			decoded.regWrite = 1'b0;
			decoded.isLoad   = 1'b0;
			decoded.isStore  = 1'b0;
		end
	end

	// ID/EX register
	always_ff @(posedge clk) begin
		if (reset) begin
			idOp <= '0;
		end else if (!stall) begin
			idOp <= decoded;
		end
	end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps
`include "rvPipe_params.svh"

module fetchStage import rvPipePkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  instrWord_t       instrData,
	output logic [`XLEN-1:0] instrAddress,
	output logic             ifValid,
	output instrWord_t       ifInstr
);

	localparam logic [`XLEN-1:0] PC_STEP = 4;

	logic [`XLEN-1:0] pc;

	assign instrAddress = pc; // instruction memory answers in the same cycle

	// ------------------------------
	// PC and IF/ID register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pc      <= '0;
			ifValid <= 1'b0;
			ifInstr <= '0;
		end else if (!stall) begin
			pc      <= pc + PC_STEP;
			ifValid <= 1'b1; // first fetch after reset is already good
			ifInstr <= instrData;
		end
	end

endmodule

// File: rvPipePkg.sv
`include "rvPipe_params.svh"

package rvPipePkg;

	// ------------------------------
	// instruction formats
	// ------------------------------
	typedef struct packed {
		logic [6:0]             funct7;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0]            imm;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0]             immHi; // imm[11:5]
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [4:0]             immLo; // imm[4:0]
		logic [6:0]             opcode;
	} sType_t;

	typedef struct packed {
		logic [19:0]            imm; // imm[31:12]
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} uType_t;

	// one fetched word, viewed through whichever format the opcode calls for
	typedef union packed {
		rType_t r;
		iType_t i;
		sType_t s;
		uType_t u;
	} instrWord_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_PASSB // lui
	} aluOp_t;

	// width and fill of a load
	typedef enum logic [2:0] {
		LK_WORD  = 3'b000,
		LK_HALFU = 3'b001,
		LK_BYTEU = 3'b010,
		LK_HALF  = 3'b011,
		LK_BYTE  = 3'b100
	} loadKind_t;

	// ------------------------------
	// stage registers
	// ------------------------------
	typedef struct packed {
		logic                   valid;
		logic                   regWrite;
		logic                   isLoad;
		logic                   isStore;
		logic                   useImm;
		aluOp_t                 aluOp;
		loadKind_t              loadKind;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`XLEN-1:0]       rs1Data;
		logic [`XLEN-1:0]       rs2Data;
		logic [`XLEN-1:0]       imm;
	} decodedOp_t;

	typedef struct packed {
		logic                   valid;
		logic                   regWrite;
		logic                   isLoad;
		logic                   isStore;
		loadKind_t              loadKind;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       aluResult;
		logic [`XLEN-1:0]       storeData;
	} memOp_t;

	typedef struct packed {
		logic                   regWrite;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       data;
	} wbEntry_t;

endpackage

// File: rvPipe_params.svh
`ifndef RVPIPE_PARAMS_SVH
`define RVPIPE_PARAMS_SVH

// ------------------------------
// datapath sizes
// ------------------------------
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// ------------------------------
// RV32I major opcodes kept here
// ------------------------------
`define OPC_OP      7'b0110011 // register-register
`define OPC_OPIMM   7'b0010011 // register-immediate
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

`endif
